// ==== source/flow_config.svh ====
`ifndef FLOW_CONFIG_SVH
`define FLOW_CONFIG_SVH

// instruction and pc width
`define FLOW_DATA_W 32

// micro-rom address width, 8 words of space
`define FLOW_UROM_AW 3

// words in the interrupt entry sequence
`define FLOW_IRQ_SEQ_LEN 4

// fetch address out of reset
`define FLOW_RESET_PC 32'h0000_0000

// handler entry, loaded when the entry sequence ends
`define FLOW_IRQ_VECTOR 32'h0000_0100

`endif

// ==== source/flow_pkg.sv ====
`include "flow_config.svh"

package flow_pkg;

   // pipeline flow states
   // RESET   first cycle out of reset, pipe forced to stall
   // CONT    normal sequential fetch
   // BRANCH  waiting for code at the branch target
   // WAITLD  data access in flight
   // STALL   code not ready, fetched word not valid
   // IRQ     micro-rom feeds the decode stage
   typedef enum logic [2:0] {
      RESET  = 3'd0,
      CONT   = 3'd1,
      BRANCH = 3'd2,
      WAITLD = 3'd3,
      STALL  = 3'd4,
      IRQ    = 3'd5
   } pstate_t;

   // pc, branch target and micro-rom word
   typedef logic [`FLOW_DATA_W-1:0] word_t;

   // micro-rom address
   typedef logic [`FLOW_UROM_AW-1:0] urom_addr_t;

endpackage

// ==== source/pipe_ctrl_if.sv ====
`timescale 1ns/100ps

// control from the flow fsm to the fetch pc unit
interface pipe_ctrl_if;

   // hold the pc
   logic stall;
   // redirect to the branch target
   logic load_target;
   // redirect to the irq vector
   logic load_vector;
   // fetched word is a real instruction
   logic valid_inst;

   // fsm side
   modport ctrl (
      output stall,
      output load_target,
      output load_vector,
      output valid_inst
   );

   // fetch side
   modport fetch (
      input stall,
      input load_target,
      input load_vector,
      input valid_inst
   );

endinterface

// ==== source/flow_ctrl.sv ====
`timescale 1ns/100ps

module flow_ctrl (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              branch_taken,
   input  logic              datamem_read,
   input  logic              datamem_write,
   input  logic              hreadyd,
   input  logic              code_ready,
   input  logic              irq,
   input  logic              seq_last,
   output flow_pkg::pstate_t pstate,
   output logic              force_stall_reset,
   output logic              output_new_pc,
   output logic              data_access_cycle,
   output logic              irq_ack,
   output logic              irq_bypass_inst_reg,
   output logic              seq_load,
   output logic              seq_inc,
   pipe_ctrl_if.ctrl         ctrl
);

   flow_pkg::pstate_t pstate_next;
   logic              mem_access;

   // read and write share the same wait path
   assign mem_access = datamem_read | datamem_write;

   // next state and control decode
   always_comb begin
      pstate_next         = flow_pkg::CONT;
      force_stall_reset   = 1'b0;
      output_new_pc       = 1'b0;
      data_access_cycle   = 1'b0;
      irq_ack             = 1'b0;
      irq_bypass_inst_reg = 1'b0;
      seq_load            = 1'b0;
      seq_inc             = 1'b0;
      ctrl.stall          = 1'b0;
      ctrl.load_target    = 1'b0;
      ctrl.load_vector    = 1'b0;
      ctrl.valid_inst     = 1'b1;

      case (pstate)
         flow_pkg::RESET: begin
            // hold everything for one cycle
            force_stall_reset = 1'b1;
            ctrl.stall        = 1'b1;
            pstate_next       = flow_pkg::CONT;
         end

         flow_pkg::CONT, flow_pkg::WAITLD: begin
            if (pstate == flow_pkg::WAITLD && !hreadyd) begin
               // data still pending, latency set by hreadyd
               ctrl.stall  = 1'b1;
               pstate_next = flow_pkg::WAITLD;
            end else if (branch_taken) begin
               // branch wins over everything
               output_new_pc    = 1'b1;
               ctrl.load_target = 1'b1;
               ctrl.stall       = 1'b1;
               pstate_next      = flow_pkg::BRANCH;
            end else if (mem_access) begin
               // early ready, so the access cycle itself does not stall
               data_access_cycle = 1'b1;
               pstate_next       = flow_pkg::WAITLD;
            end else if (irq && pstate == flow_pkg::CONT) begin
               // start the entry sequence from word 0
               irq_ack     = 1'b1;
               seq_load    = 1'b1;
               ctrl.stall  = 1'b1;
               pstate_next = flow_pkg::IRQ;
            end else begin
               pstate_next = flow_pkg::CONT;
            end
         end

         flow_pkg::BRANCH: begin
            // wait for code at the target
            ctrl.stall  = !code_ready;
            pstate_next = code_ready ? flow_pkg::CONT : flow_pkg::BRANCH;
         end

         flow_pkg::STALL: begin
            ctrl.valid_inst = 1'b0;
            ctrl.stall      = !code_ready;
            pstate_next     = code_ready ? flow_pkg::CONT : flow_pkg::STALL;
         end

         flow_pkg::IRQ: begin
            // decode takes micro-rom words instead of fetched code
            ctrl.stall          = 1'b1;
            irq_bypass_inst_reg = 1'b1;
            if (seq_last) begin
               // last word, jump to the handler
               ctrl.load_vector = 1'b1;
               pstate_next      = flow_pkg::CONT;
            end else begin
               seq_inc     = 1'b1;
               pstate_next = flow_pkg::IRQ;
            end
         end

         default: begin
            pstate_next = flow_pkg::CONT;
         end
      endcase
   end

   // state register
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pstate <= flow_pkg::RESET;
      end else begin
         pstate <= pstate_next;
      end
   end

endmodule

// ==== source/urom_sequencer.sv ====
`timescale 1ns/100ps

`include "flow_config.svh"

module urom_sequencer (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 seq_load,
   input  logic                 seq_inc,
   output flow_pkg::urom_addr_t addr,
   output logic                 seq_last
);

   // address of the final word in the sequence
   localparam flow_pkg::urom_addr_t LAST_ADDR =
      flow_pkg::urom_addr_t'(`FLOW_IRQ_SEQ_LEN - 1);

   // address counter, load has priority
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         addr <= '0;
      end else if (seq_load) begin
         // sequence always starts at word 0
         addr <= '0;
      end else if (seq_inc) begin
         addr <= addr + 1'b1;
      end
   end

   // end of sequence flag
   assign seq_last = (addr == LAST_ADDR);

endmodule

// ==== source/irq_urom.sv ====
`timescale 1ns/100ps

module irq_urom (
   input  flow_pkg::urom_addr_t addr,
   output flow_pkg::word_t      dout
);

   // sw ra, -4(sp)
   localparam flow_pkg::word_t SAVE_RA    = 32'hFE11_2E23;
   // sw t0, -8(sp)
   localparam flow_pkg::word_t SAVE_T0    = 32'hFE51_2C23;
   // csrr t0, mcause
   localparam flow_pkg::word_t READ_CAUSE = 32'h3420_22F3;
   // jal x0, 0, the pc unit supplies the vector
   localparam flow_pkg::word_t JUMP_VEC   = 32'h0000_006F;
   // addi x0, x0, 0
   localparam flow_pkg::word_t NOP        = 32'h0000_0013;

   // interrupt entry sequence
   always_comb begin
      case (addr)
         3'd0:    dout = SAVE_RA;
         3'd1:    dout = SAVE_T0;
         3'd2:    dout = READ_CAUSE;
         3'd3:    dout = JUMP_VEC;
         // spare words
         default: dout = NOP;
      endcase
   end

endmodule

// ==== source/fetch_pc.sv ====
`timescale 1ns/100ps

`include "flow_config.svh"

module fetch_pc (
   input  logic            clk,
   input  logic            rst_n,
   input  flow_pkg::word_t branch_target,
   pipe_ctrl_if.fetch      fetch,
   output flow_pkg::word_t pc
);

   // one 32-bit instruction per fetch
   localparam flow_pkg::word_t PC_STEP = flow_pkg::word_t'(4);

   logic advance;

   // move on only with a real word and no stall
   assign advance = !fetch.stall && fetch.valid_inst;

   // pc register
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc <= `FLOW_RESET_PC;
      end else if (fetch.load_target) begin
         // taken branch
         pc <= branch_target;
      end else if (fetch.load_vector) begin
         // end of irq entry sequence
         pc <= `FLOW_IRQ_VECTOR;
      end else if (advance) begin
         pc <= pc + PC_STEP;
      end
   end

endmodule

// ==== source/pipe_flow_top.sv ====
`timescale 1ns/100ps

module pipe_flow_top (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              branch_taken,
   input  logic              datamem_read,
   input  logic              datamem_write,
   input  logic              hreadyd,
   input  logic              code_ready,
   input  logic              irq,
   input  flow_pkg::word_t   branch_target,
   output flow_pkg::word_t   pc,
   output flow_pkg::pstate_t pstate,
   output logic              force_stall_reset,
   output logic              output_new_pc,
   output logic              data_access_cycle,
   output logic              irq_ack,
   output logic              irq_bypass_inst_reg,
   output flow_pkg::word_t   inst_irq
);

   // sequencer handshake
   logic                 seq_load;
   logic                 seq_inc;
   logic                 seq_last;
   flow_pkg::urom_addr_t urom_addr;

   // fsm to fetch control bundle
   pipe_ctrl_if ctrl_bus ();

   flow_ctrl u_flow_ctrl (
      .clk                 (clk),
      .rst_n               (rst_n),
      .branch_taken        (branch_taken),
      .datamem_read        (datamem_read),
      .datamem_write       (datamem_write),
      .hreadyd             (hreadyd),
      .code_ready          (code_ready),
      .irq                 (irq),
      .seq_last            (seq_last),
      .pstate              (pstate),
      .force_stall_reset   (force_stall_reset),
      .output_new_pc       (output_new_pc),
      .data_access_cycle   (data_access_cycle),
      .irq_ack             (irq_ack),
      .irq_bypass_inst_reg (irq_bypass_inst_reg),
      .seq_load            (seq_load),
      .seq_inc             (seq_inc),
      .ctrl                (ctrl_bus)
   );

   urom_sequencer u_urom_sequencer (
      .clk      (clk),
      .rst_n    (rst_n),
      .seq_load (seq_load),
      .seq_inc  (seq_inc),
      .addr     (urom_addr),
      .seq_last (seq_last)
   );

   // rom word goes straight out to decode
   irq_urom u_irq_urom (
      .addr (urom_addr),
      .dout (inst_irq)
   );

   fetch_pc u_fetch_pc (
      .clk           (clk),
      .rst_n         (rst_n),
      .branch_target (branch_target),
      .fetch         (ctrl_bus),
      .pc            (pc)
   );

endmodule

// ==== verification/pipe_flow_tb.sv ====
`timescale 1ns/100ps

`include "flow_config.svh"

module pipe_flow_tb;

   // words per stimulus line, room for the whole table
   localparam int NUM_COLS  = 16;
   localparam int MAX_LINES = 64;

   logic              clk = 1'b0;
   logic              rst_n;
   logic              branch_taken;
   logic              datamem_read;
   logic              datamem_write;
   logic              hreadyd;
   logic              code_ready;
   logic              irq;
   flow_pkg::word_t   branch_target;
   flow_pkg::word_t   pc;
   flow_pkg::pstate_t pstate;
   logic              force_stall_reset;
   logic              output_new_pc;
   logic              data_access_cycle;
   logic              irq_ack;
   logic              irq_bypass_inst_reg;
   flow_pkg::word_t   inst_irq;

   // flat table, NUM_COLS words per cycle
   logic [31:0] stim_mem [0:NUM_COLS*MAX_LINES-1];

   int num_lines;
   int timeout_limit = 1000;
   int cycle_count = 0;
   int test_errors = 0;
   int error_count = 0;
   int tests_passed = 0;
   int tests_failed = 0;

   pipe_flow_top pipe_flow_top_inst (
      .clk                 (clk),
      .rst_n               (rst_n),
      .branch_taken        (branch_taken),
      .datamem_read        (datamem_read),
      .datamem_write       (datamem_write),
      .hreadyd             (hreadyd),
      .code_ready          (code_ready),
      .irq                 (irq),
      .branch_target       (branch_target),
      .pc                  (pc),
      .pstate              (pstate),
      .force_stall_reset   (force_stall_reset),
      .output_new_pc       (output_new_pc),
      .data_access_cycle   (data_access_cycle),
      .irq_ack             (irq_ack),
      .irq_bypass_inst_reg (irq_bypass_inst_reg),
      .inst_irq            (inst_irq)
   );

   // 40 ns clock
   always #20 clk = ~clk;

   // run limit in cycles
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= timeout_limit) begin
         $display("timeout: run still going after %0d cycles", cycle_count);
         $display("TEST FAIL");
         $finish;
      end
   end

   task automatic check_state(input string name, input flow_pkg::pstate_t expected,
                              input flow_pkg::pstate_t actual);
      if (actual !== expected) begin
         $display("error at %0t ns: %s expected %s got %s", $time, name,
                  expected.name(), actual.name());
         test_errors++;
      end
   endtask

   task automatic check_word(input string name, input flow_pkg::word_t expected,
                             input flow_pkg::word_t actual);
      if (actual !== expected) begin
         $display("error at %0t ns: %s expected %h got %h", $time, name, expected, actual);
         test_errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("error at %0t ns: %s expected %b got %b", $time, name, expected, actual);
         test_errors++;
      end
   endtask

   // inputs for one cycle, just after the rising edge
   task automatic drive_line(input int idx);
      int base;
      base = idx * NUM_COLS;
      branch_taken  <= stim_mem[base + 1][0];
      datamem_read  <= stim_mem[base + 2][0];
      datamem_write <= stim_mem[base + 3][0];
      hreadyd       <= stim_mem[base + 4][0];
      code_ready    <= stim_mem[base + 5][0];
      irq           <= stim_mem[base + 6][0];
      branch_target <= stim_mem[base + 7];
   endtask

   // outputs at the falling edge, settled by then
   task automatic compare_line(input int idx);
      int base;
      base = idx * NUM_COLS;
      check_state("pstate", flow_pkg::pstate_t'(stim_mem[base + 8][2:0]), pstate);
      check_word("pc", stim_mem[base + 9], pc);
      check_bit("force_stall_reset", stim_mem[base + 10][0], force_stall_reset);
      check_bit("output_new_pc", stim_mem[base + 11][0], output_new_pc);
      check_bit("data_access_cycle", stim_mem[base + 12][0], data_access_cycle);
      check_bit("irq_ack", stim_mem[base + 13][0], irq_ack);
      check_bit("irq_bypass_inst_reg", stim_mem[base + 14][0], irq_bypass_inst_reg);
      check_word("inst_irq", stim_mem[base + 15], inst_irq);
   endtask

   task automatic close_test(input int test_num);
      if (test_errors == 0) begin
         $display("test %0d passed", test_num);
         tests_passed++;
      end else begin
         $display("test %0d failed with %0d mismatches", test_num, test_errors);
         tests_failed++;
      end
      error_count += test_errors;
      test_errors = 0;
   endtask

   initial begin
      int idx;
      int cur_test;
      rst_n         <= 1'b0;
      branch_taken  <= 1'b0;
      datamem_read  <= 1'b0;
      datamem_write <= 1'b0;
      hreadyd       <= 1'b1;
      code_ready    <= 1'b1;
      irq           <= 1'b0;
      branch_target <= '0;
      $readmemh("verification/pipe_flow_stim.txt", stim_mem);
      // table ends at the all-zero line
      num_lines = 0;
      while (num_lines < MAX_LINES && stim_mem[num_lines * NUM_COLS] != 0) begin
         num_lines++;
      end
      if (num_lines == 0) begin
         $display("stimulus table is empty or could not be read");
         error_count++;
      end
      timeout_limit = num_lines + 16 + 50;
      cur_test = stim_mem[0];

      // still in reset, pipe frozen
      repeat (15) @(posedge clk);
      @(negedge clk);
      check_state("pstate", flow_pkg::RESET, pstate);
      check_word("pc", `FLOW_RESET_PC, pc);
      check_bit("force_stall_reset", 1'b1, force_stall_reset);
      check_bit("output_new_pc", 1'b0, output_new_pc);
      check_bit("data_access_cycle", 1'b0, data_access_cycle);
      check_bit("irq_ack", 1'b0, irq_ack);
      check_bit("irq_bypass_inst_reg", 1'b0, irq_bypass_inst_reg);
      @(posedge clk);
      rst_n <= 1'b1;

      for (idx = 0; idx < num_lines; idx++) begin
         if (stim_mem[idx * NUM_COLS] != cur_test) begin
            close_test(cur_test);
            cur_test = stim_mem[idx * NUM_COLS];
         end
         drive_line(idx);
         @(negedge clk);
         compare_line(idx);
         @(posedge clk);
      end
      close_test(cur_test);

      $display("tests passed: %0d, tests failed: %0d, mismatches: %0d",
               tests_passed, tests_failed, error_count);
      if (error_count == 0 && tests_failed == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

// ==== verification/pipe_flow_stim.txt ====
// test br rd wr hready cready irq target | pstate pc fsr newpc dac ack bypass inst_irq
// one line per cycle after reset release, all-zero line closes the table
1 0 0 0 1 1 0 00000000 0 00000000 1 0 0 0 0 FE112E23
2 0 0 0 1 1 0 00000000 1 00000000 0 0 0 0 0 FE112E23
2 0 0 0 1 1 0 00000000 1 00000004 0 0 0 0 0 FE112E23
2 1 0 0 1 1 0 00000200 1 00000008 0 1 0 0 0 FE112E23
2 0 0 0 1 0 0 00000200 2 00000200 0 0 0 0 0 FE112E23
2 0 0 0 1 0 0 00000200 2 00000200 0 0 0 0 0 FE112E23
2 0 0 0 1 1 0 00000200 2 00000200 0 0 0 0 0 FE112E23
2 0 0 0 1 1 0 00000000 1 00000204 0 0 0 0 0 FE112E23
3 0 1 0 0 1 0 00000000 1 00000208 0 0 1 0 0 FE112E23
3 0 0 0 0 1 0 00000000 3 0000020C 0 0 0 0 0 FE112E23
3 0 0 0 0 1 0 00000000 3 0000020C 0 0 0 0 0 FE112E23
3 0 0 1 1 1 0 00000000 3 0000020C 0 0 1 0 0 FE112E23
3 0 0 0 1 1 0 00000000 3 00000210 0 0 0 0 0 FE112E23
3 0 0 0 1 1 0 00000000 1 00000214 0 0 0 0 0 FE112E23
4 0 0 0 1 1 1 00000000 1 00000218 0 0 0 1 0 FE112E23
4 0 0 0 1 1 0 00000000 5 00000218 0 0 0 0 1 FE112E23
4 0 0 0 1 1 0 00000000 5 00000218 0 0 0 0 1 FE512C23
4 0 0 0 1 1 0 00000000 5 00000218 0 0 0 0 1 342022F3
4 0 0 0 1 1 0 00000000 5 00000218 0 0 0 0 1 0000006F
4 0 0 0 1 1 0 00000000 1 00000100 0 0 0 0 0 0000006F
5 1 1 0 1 1 1 00000300 1 00000104 0 1 0 0 0 0000006F
5 0 0 0 1 1 0 00000300 2 00000300 0 0 0 0 0 0000006F
5 0 1 0 1 1 1 00000000 1 00000304 0 0 1 0 0 0000006F
5 0 0 0 1 1 1 00000000 3 00000308 0 0 0 0 0 0000006F
5 0 0 0 1 1 0 00000000 1 0000030C 0 0 0 0 0 0000006F
0 0 0 0 0 0 0 00000000 0 00000000 0 0 0 0 0 00000000

// ==== pipe_flow_top.f ====
+incdir+source
source/flow_pkg.sv
source/pipe_ctrl_if.sv
source/flow_ctrl.sv
source/urom_sequencer.sv
source/irq_urom.sv
source/fetch_pc.sv
source/pipe_flow_top.sv
verification/pipe_flow_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --timescale 1ns/100ps
TOP      = pipe_flow_tb
FILELIST = pipe_flow_top.f
OBJ_DIR  = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# exit status comes from the search for the pass line
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q '^TEST PASS$$'

clean:
	rm -rf $(OBJ_DIR)
